//--- verilog/arrayMemPkg.sv
// Array memory shared definitions
// Sizes, element types, operation and error codes, and the request,
// response and table verdict structs used by every block

package arrayMemPkg;

  //------------------------------------------------------------
  // Sizes
  //------------------------------------------------------------
  localparam int arrayAddrBits = 2;                 // Bits in an array number
  localparam int indexBits     = 3;                 // Bits in an element index
  localparam int dataBits      = 12;                // Element width
  localparam int arrayCount    = 1 << arrayAddrBits;
  localparam int arrayLength   = 1 << indexBits;

  typedef logic [arrayAddrBits-1:0] arrayId;        // Array number
  typedef logic [indexBits-1:0]     elementIndex;   // Element within an array
  typedef logic [indexBits:0]       arraySize;      // 0 up to arrayLength
  typedef logic [dataBits-1:0]      dataWord;       // Element value

  //------------------------------------------------------------
  // Operation and error codes
  //------------------------------------------------------------
  typedef enum logic [4:0] {
    opClear,        // Free every array
    opAlloc,        // New empty array
    opFree,
    opWrite,
    opRead,
    opSize,
    opPush,
    opPop,
    opAdd,          // Element ops from here on
    opAddAfter,     // Returns old value
    opSub,
    opSubAfter,     // Returns old value
    opShiftLeft,
    opShiftRight,
    opNot,
    opOr,
    opXor,
    opAnd
  } memOp;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,
    errOutOfBounds,
    errFull,
    errEmpty,
    errNoMemory
  } memError;

  //------------------------------------------------------------
  // Bundles
  //------------------------------------------------------------
  typedef struct packed {
    memOp        op;
    arrayId      array;
    elementIndex index;
    dataWord     data;
  } memRequest;

  typedef struct packed {
    dataWord data;
    memError error;
  } memResponse;

  // Target is size-wide so opSize and opAlloc can return through it
  typedef struct packed {
    memError     error;
    arraySize    target;      // Array number, or size for opSize
    elementIndex slot;        // Element to access
    logic        storeWrite;  // Element gets written back
  } tableVerdict;

endpackage

//--- verilog/requestPort.sv
// Request port
// Four-phase req/ack handshake toward the client. Latches one request,
// pulses execute for a cycle and holds the registered response until
// the client drops reqValid

`timescale 1ns/1ns

module requestPort (
  input  logic                   clock,
  input  logic                   reset,        // Active low
  input  logic                   reqValid,
  input  arrayMemPkg::memRequest request,
  input  arrayMemPkg::dataWord   result,       // From element store
  input  arrayMemPkg::memError   verdictError, // From array table
  output arrayMemPkg::memRequest current,
  output logic                   execute,
  output logic                   ackValid,
  output arrayMemPkg::memResponse response
);

  import arrayMemPkg::*;

  typedef enum logic [1:0] {
    stIdle,         // Waiting for reqValid
    stExecute,      // Table and store act this cycle
    stAcknowledge,  // Response captured
    stRelease       // ackValid high until reqValid falls
  } portState;

  portState state;

  //------------------------------------------------------------
  // Handshake FSM
  //------------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      state <= stIdle;
    end else begin
      case (state)
        stIdle: begin
          if (reqValid) begin
            state <= stExecute;                 // Request latched below
          end
        end
        stExecute: begin
          state <= stAcknowledge;
        end
        stAcknowledge: begin
          state <= stRelease;
        end
        stRelease: begin
          if (!reqValid) begin
            state <= stIdle;                    // Phase 4 done
          end
        end
        default: begin
          state <= stIdle;
        end
      endcase
    end
  end

  assign execute  = (state == stExecute);     // Single cycle pulse
  assign ackValid = (state == stRelease);

  //------------------------------------------------------------
  // Request and response registers
  //------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (state == stIdle && reqValid) begin
      current <= request;                       // Held for the whole transfer
    end
  end

  // Response sampled at the execute edge, before table and store update
  always_ff @(posedge clock) begin
    if (execute) begin
      response.error <= verdictError;
      if (verdictError == errNone) begin
        response.data <= result;
      end else begin
        response.data <= '0;                    // Errors return zero data
      end
    end
  end

endmodule

//--- verilog/arrayTable.sv
// Array table
// Allocation flags, per-array sizes and the stack of freed arrays.
// Checks each request, picks the element slot for the store and
// updates its own bookkeeping when the request succeeds

`timescale 1ns/1ns

module arrayTable (
  input  logic                     clock,
  input  logic                     reset,    // Active low
  input  logic                     execute,
  input  arrayMemPkg::memRequest   current,
  output arrayMemPkg::tableVerdict verdict
);

  import arrayMemPkg::*;

  logic [arrayCount-1:0]  allocated;         // One flag per array
  arraySize               sizes [arrayCount];
  arrayId                 freeStack [arrayCount];
  logic [arrayAddrBits:0] freeDepth;         // Entries on free stack
  logic [arrayAddrBits:0] nextNew;           // Next never-used array

  arraySize currentSize;
  arrayId   freeTop;
  arrayId   newArray;
  logic     isAllocated;
  logic     inBounds;
  logic     accept;

  assign currentSize = sizes[current.array];
  assign isAllocated = allocated[current.array];
  assign inBounds    = ({1'b0, current.index} < currentSize);
  assign freeTop     = arrayId'(freeDepth - 1'b1);
  assign newArray    = verdict.target[arrayAddrBits-1:0];
  assign accept      = execute && (verdict.error == errNone);

  //------------------------------------------------------------
  // Request checking
  //------------------------------------------------------------
  // Allocation is checked first, then bounds, then full or empty
  always_comb begin
    verdict.error      = errNone;
    verdict.target     = arraySize'(current.array);
    verdict.slot       = current.index;
    verdict.storeWrite = 1'b0;
    case (current.op)
      opClear: begin
        verdict.target = '0;
      end
      opAlloc: begin
        if (freeDepth != '0) begin
          verdict.target = arraySize'(freeStack[freeTop]);   // Reuse freed array
        end else if (nextNew < arrayCount) begin
          verdict.target = arraySize'(nextNew);
        end else begin
          verdict.error = errNoMemory;
        end
      end
      opFree: begin
        if (!isAllocated) verdict.error = errNotAllocated;   // Also stops double free
      end
      opWrite: begin
        if (!isAllocated) verdict.error = errNotAllocated;
        else verdict.storeWrite = 1'b1;
      end
      opRead: begin
        if (!isAllocated) verdict.error = errNotAllocated;
        else if (!inBounds) verdict.error = errOutOfBounds;
      end
      opSize: begin
        if (!isAllocated) verdict.error = errNotAllocated;
        else verdict.target = currentSize;
      end
      opPush: begin
        if (!isAllocated) begin
          verdict.error = errNotAllocated;
        end else if (currentSize == arraySize'(arrayLength)) begin
          verdict.error = errFull;
        end else begin
          verdict.slot       = elementIndex'(currentSize);       // Append position
          verdict.storeWrite = 1'b1;
        end
      end
      opPop: begin
        if (!isAllocated) verdict.error = errNotAllocated;
        else if (currentSize == '0) verdict.error = errEmpty;
        else verdict.slot = elementIndex'(currentSize - 1'b1);  // Last element
      end
      default: begin
        // Element arithmetic
        if (!isAllocated) verdict.error = errNotAllocated;
        else if (!inBounds) verdict.error = errOutOfBounds;
        else verdict.storeWrite = 1'b1;
      end
    endcase
  end

  //------------------------------------------------------------
  // Bookkeeping updates
  //------------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      allocated <= '0;
      freeDepth <= '0;
      nextNew   <= '0;
    end else if (accept) begin
      case (current.op)
        opClear: begin
          allocated <= '0;
          freeDepth <= '0;
          nextNew   <= '0;                      // Allocation restarts at 0
        end
        opAlloc: begin
          allocated[newArray] <= 1'b1;
          if (freeDepth != '0) freeDepth <= freeDepth - 1'b1;
          else nextNew <= nextNew + 1'b1;
        end
        opFree: begin
          allocated[current.array] <= 1'b0;   // The freed array's own flag
          freeDepth                <= freeDepth + 1'b1;
        end
        default: ;
      endcase
    end
  end

  // Per-array sizes and free stack entries
  always_ff @(posedge clock) begin
    if (accept) begin
      case (current.op)
        opAlloc: sizes[newArray] <= '0;
        opFree:  freeStack[arrayId'(freeDepth)] <= current.array;
        opWrite: begin
          if (!inBounds) sizes[current.array] <= arraySize'(current.index) + 1'b1;
        end
        opPush:  sizes[current.array] <= currentSize + 1'b1;
        opPop:   sizes[current.array] <= currentSize - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

//--- verilog/elementStore.sv
// Element store
// Holds every element of every array and applies the in-place element
// operations. The addressed element is read and the result formed in the
// execute cycle; the new value is written back at the same edge

`timescale 1ns/1ns

module elementStore (
  input  logic                     clock,
  input  logic                     execute,
  input  arrayMemPkg::memRequest   current,
  input  arrayMemPkg::tableVerdict verdict,
  output arrayMemPkg::dataWord     result
);

  import arrayMemPkg::*;

  dataWord storage [arrayCount][arrayLength];   // One block per array

  arrayId      targetArray;
  logic [3:0]  shiftAmount;
  dataWord     oldValue;
  dataWord     newValue;

  assign targetArray = verdict.target[arrayAddrBits-1:0];
  assign shiftAmount = current.data[3:0];        // Low bits only
  assign oldValue    = storage[targetArray][verdict.slot];

  //------------------------------------------------------------
  // New element value
  //------------------------------------------------------------
  always_comb begin
    case (current.op)
      opWrite,
      opPush:       newValue = current.data;
      opAdd,
      opAddAfter:   newValue = oldValue + current.data;   // Wraps at dataBits
      opSub,
      opSubAfter:   newValue = oldValue - current.data;
      opShiftLeft:  newValue = oldValue << shiftAmount;
      opShiftRight: newValue = oldValue >> shiftAmount;
      opNot:        newValue = ~oldValue;
      opOr:         newValue = oldValue | current.data;
      opXor:        newValue = oldValue ^ current.data;
      opAnd:        newValue = oldValue & current.data;
      default:      newValue = oldValue;
    endcase
  end

  //------------------------------------------------------------
  // Returned word
  //------------------------------------------------------------
  always_comb begin
    case (current.op)
      opClear,
      opFree:     result = '0;
      opAlloc,
      opSize:     result = dataWord'(verdict.target);   // Number or size from table
      opRead,
      opPop,
      opAddAfter,
      opSubAfter: result = oldValue;
      default:    result = newValue;                     // Writes and element ops
    endcase
  end

  // Write-back of requests the table accepted
  always_ff @(posedge clock) begin
    if (execute && verdict.storeWrite) begin
      storage[targetArray][verdict.slot] <= newValue;
    end
  end

endmodule

//--- verilog/arrayMemTop.sv
// Array memory top level
// Request port in front of the array table and the element store

`timescale 1ns/1ns

module arrayMemTop (
  input  logic                    clock,
  input  logic                    reset,     // Active low
  input  logic                    reqValid,
  input  arrayMemPkg::memRequest  request,
  output logic                    ackValid,
  output arrayMemPkg::memResponse response
);

  import arrayMemPkg::*;

  memRequest   current;    // Latched request
  logic        execute;
  tableVerdict verdict;
  dataWord     result;

  //------------------------------------------------------------
  // Blocks
  //------------------------------------------------------------
  requestPort i_requestPort (
    .clock        (clock),
    .reset        (reset),
    .reqValid     (reqValid),
    .request      (request),
    .result       (result),
    .verdictError (verdict.error),
    .current      (current),
    .execute      (execute),
    .ackValid     (ackValid),
    .response     (response)
  );

  arrayTable i_arrayTable (
    .clock   (clock),
    .reset   (reset),
    .execute (execute),
    .current (current),
    .verdict (verdict)
  );

  elementStore i_elementStore (
    .clock   (clock),
    .execute (execute),
    .current (current),
    .verdict (verdict),
    .result  (result)
  );

endmodule

//--- sim/arrayMemVectors.svh
// Array memory directed vectors
// Request fields, extra cycles to hold reqValid after ack, expected response

`ifndef ARRAY_MEM_VECTORS_SVH
`define ARRAY_MEM_VECTORS_SVH

typedef struct packed {
  memOp        op;
  arrayId      array;
  elementIndex index;
  dataWord     data;
  logic [3:0]  hold;       // Extra cycles with reqValid high
  dataWord     expData;
  memError     expError;
} vectorRow;

localparam int vectorCount = 57;

// op, array, index, data, hold, expected data, expected error
localparam vectorRow vectors [vectorCount] = '{
  '{opAlloc,      2'd0, 3'd0, 12'h000, 4'd0, 12'h000, errNone},  // Allocation order
  '{opAlloc,      2'd0, 3'd0, 12'h000, 4'd0, 12'h001, errNone},
  '{opAlloc,      2'd0, 3'd0, 12'h000, 4'd0, 12'h002, errNone},
  '{opAlloc,      2'd0, 3'd0, 12'h000, 4'd0, 12'h003, errNone},
  '{opAlloc,      2'd0, 3'd0, 12'h000, 4'd0, 12'h000, errNoMemory},
  '{opFree,       2'd2, 3'd0, 12'h000, 4'd0, 12'h000, errNone},
  '{opFree,       2'd0, 3'd0, 12'h000, 4'd0, 12'h000, errNone},
  '{opAlloc,      2'd0, 3'd0, 12'h000, 4'd0, 12'h000, errNone},  // Last freed first
  '{opAlloc,      2'd0, 3'd0, 12'h000, 4'd0, 12'h002, errNone},
  '{opFree,       2'd1, 3'd0, 12'h000, 4'd0, 12'h000, errNone},
  '{opFree,       2'd1, 3'd0, 12'h000, 4'd0, 12'h000, errNotAllocated},
  '{opClear,      2'd0, 3'd0, 12'h000, 4'd0, 12'h000, errNone},
  '{opAlloc,      2'd0, 3'd0, 12'h000, 4'd0, 12'h000, errNone},
  '{opWrite,      2'd0, 3'd5, 12'h5A3, 4'd0, 12'h5A3, errNone},  // Write, read, size
  '{opSize,       2'd0, 3'd0, 12'h000, 4'd0, 12'h006, errNone},
  '{opRead,       2'd0, 3'd5, 12'h000, 4'd0, 12'h5A3, errNone},
  '{opRead,       2'd0, 3'd6, 12'h000, 4'd0, 12'h000, errOutOfBounds},
  '{opRead,       2'd3, 3'd0, 12'h000, 4'd0, 12'h000, errNotAllocated},
  '{opWrite,      2'd3, 3'd0, 12'h001, 4'd0, 12'h000, errNotAllocated},
  '{opAlloc,      2'd0, 3'd0, 12'h000, 4'd0, 12'h001, errNone},  // Push and pop
  '{opPush,       2'd1, 3'd0, 12'h101, 4'd0, 12'h101, errNone},
  '{opPush,       2'd1, 3'd0, 12'h102, 4'd0, 12'h102, errNone},
  '{opPush,       2'd1, 3'd0, 12'h103, 4'd0, 12'h103, errNone},
  '{opPush,       2'd1, 3'd0, 12'h104, 4'd0, 12'h104, errNone},
  '{opPush,       2'd1, 3'd0, 12'h105, 4'd0, 12'h105, errNone},
  '{opPush,       2'd1, 3'd0, 12'h106, 4'd0, 12'h106, errNone},
  '{opPush,       2'd1, 3'd0, 12'h107, 4'd0, 12'h107, errNone},
  '{opPush,       2'd1, 3'd0, 12'h108, 4'd0, 12'h108, errNone},
  '{opPush,       2'd1, 3'd0, 12'h1FF, 4'd0, 12'h000, errFull},
  '{opPop,        2'd1, 3'd0, 12'h000, 4'd0, 12'h108, errNone},
  '{opPop,        2'd1, 3'd0, 12'h000, 4'd0, 12'h107, errNone},
  '{opPop,        2'd1, 3'd0, 12'h000, 4'd0, 12'h106, errNone},
  '{opPop,        2'd1, 3'd0, 12'h000, 4'd0, 12'h105, errNone},
  '{opPop,        2'd1, 3'd0, 12'h000, 4'd0, 12'h104, errNone},
  '{opPop,        2'd1, 3'd0, 12'h000, 4'd0, 12'h103, errNone},
  '{opPop,        2'd1, 3'd0, 12'h000, 4'd0, 12'h102, errNone},
  '{opPop,        2'd1, 3'd0, 12'h000, 4'd0, 12'h101, errNone},
  '{opPop,        2'd1, 3'd0, 12'h000, 4'd0, 12'h000, errEmpty},
  '{opSize,       2'd1, 3'd0, 12'h000, 4'd0, 12'h000, errNone},
  '{opWrite,      2'd0, 3'd0, 12'hFF0, 4'd0, 12'hFF0, errNone},  // Element arithmetic
  '{opAdd,        2'd0, 3'd0, 12'h020, 4'd0, 12'h010, errNone},  // Wraps
  '{opRead,       2'd0, 3'd0, 12'h000, 4'd0, 12'h010, errNone},
  '{opAddAfter,   2'd0, 3'd0, 12'h005, 4'd0, 12'h010, errNone},
  '{opRead,       2'd0, 3'd0, 12'h000, 4'd0, 12'h015, errNone},
  '{opSub,        2'd0, 3'd0, 12'h020, 4'd0, 12'hFF5, errNone},  // Wraps below zero
  '{opSubAfter,   2'd0, 3'd0, 12'h0F5, 4'd0, 12'hFF5, errNone},
  '{opRead,       2'd0, 3'd0, 12'h000, 4'd0, 12'hF00, errNone},
  '{opShiftRight, 2'd0, 3'd0, 12'h004, 4'd0, 12'h0F0, errNone},
  '{opShiftLeft,  2'd0, 3'd0, 12'h013, 4'd0, 12'h780, errNone},  // Amount is 3
  '{opNot,        2'd0, 3'd0, 12'h000, 4'd0, 12'h87F, errNone},
  '{opOr,         2'd0, 3'd0, 12'h100, 4'd0, 12'h97F, errNone},
  '{opXor,        2'd0, 3'd0, 12'h0FF, 4'd0, 12'h980, errNone},
  '{opAnd,        2'd0, 3'd0, 12'h8C0, 4'd0, 12'h880, errNone},
  '{opRead,       2'd0, 3'd0, 12'h000, 4'd0, 12'h880, errNone},
  '{opAdd,        2'd0, 3'd6, 12'h001, 4'd0, 12'h000, errOutOfBounds},
  '{opPush,       2'd1, 3'd0, 12'h0AB, 4'd5, 12'h0AB, errNone},  // Held request
  '{opSize,       2'd1, 3'd0, 12'h000, 4'd0, 12'h001, errNone}   // Ran only once
};

`endif

//--- sim/arrayMemTb.sv
// Array memory testbench
// Directed table and seeded random traffic through the req/ack port,
// checked against a reference model of the array rules

`timescale 1ns/1ns

module arrayMemTb;

  import arrayMemPkg::*;

  `include "arrayMemVectors.svh"

  localparam int randomCount      = 300;
  localparam int cyclesPerRequest = 20;

  logic       clock;
  logic       reset;
  logic       reqValid;
  memRequest  request;
  logic       ackValid;
  memResponse response;

  // Reference model state
  bit       modelAllocated [arrayCount];
  arraySize modelSize [arrayCount];
  arrayId   modelStack [arrayCount];
  int       modelDepth;
  int       modelNext;
  dataWord  modelMem [arrayCount][arrayLength];
  bit       modelKnown [arrayCount][arrayLength];   // Element ever written

  arrayMemTop i_arrayMemTop (
    .clock    (clock),
    .reset    (reset),
    .reqValid (reqValid),
    .request  (request),
    .ackValid (ackValid),
    .response (response)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Watchdog sized for every request of the run
  initial begin
    #((2 + (vectorCount + randomCount) * cyclesPerRequest) * 10);
    $display("Timeout: the DUT did not finish the requests in time");
    $display("ERRORS FOUND");
    $fatal(1);
  end

  //------------------------------------------------------------
  // Checks
  //------------------------------------------------------------
  task automatic reportFailure(input string what);
    $display("%s at %0t", what, $time);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic checkData(input string name, input dataWord got, input dataWord exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic checkError(input string name, input memError got, input memError exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  //------------------------------------------------------------
  // Reference model
  //------------------------------------------------------------
  function automatic dataWord elementValue(input memOp op, input dataWord old,
                                           input dataWord data);
    case (op)
      opAdd, opAddAfter: return old + data;
      opSub, opSubAfter: return old - data;
      opShiftLeft:       return old << data[3:0];
      opShiftRight:      return old >> data[3:0];
      opNot:             return ~old;
      opOr:              return old | data;
      opXor:             return old ^ data;
      default:           return old & data;
    endcase
  endfunction

  task automatic applyModel(input memRequest r, output dataWord d, output memError e,
                            output bit known);
    arrayId      id;
    arraySize    sz;
    elementIndex slot;
    dataWord     old;
    d     = '0;
    e     = errNone;
    known = 1'b1;
    id    = r.array;
    sz    = modelSize[r.array];
    if (r.op == opClear) begin
      for (int i = 0; i < arrayCount; i++) modelAllocated[i] = 1'b0;
      modelDepth = 0;
      modelNext  = 0;
    end else if (r.op == opAlloc) begin
      if (modelDepth > 0) begin
        modelDepth--;
        id = modelStack[modelDepth];                 // Reuse last freed
      end else if (modelNext < arrayCount) begin
        id = arrayId'(modelNext);
        modelNext++;
      end else begin
        e = errNoMemory;
      end
      if (e == errNone) begin
        modelAllocated[id] = 1'b1;
        modelSize[id]      = '0;
        d                  = dataWord'(id);
      end
    end else if (!modelAllocated[r.array]) begin
      e = errNotAllocated;
    end else begin
      case (r.op)
        opFree: begin
          modelAllocated[id]     = 1'b0;
          modelStack[modelDepth] = id;
          modelDepth++;
        end
        opWrite: begin
          modelMem[id][r.index]   = r.data;
          modelKnown[id][r.index] = 1'b1;
          if (int'(r.index) >= int'(sz)) modelSize[id] = arraySize'(r.index) + 4'd1;
          d = r.data;
        end
        opSize: d = dataWord'(sz);
        opPush: begin
          if (int'(sz) == arrayLength) begin
            e = errFull;
          end else begin
            slot                 = elementIndex'(sz);
            modelMem[id][slot]   = r.data;
            modelKnown[id][slot] = 1'b1;
            modelSize[id]        = sz + 4'd1;
            d                    = r.data;
          end
        end
        opPop: begin
          if (sz == '0) begin
            e = errEmpty;
          end else begin
            slot          = elementIndex'(sz - 4'd1);
            modelSize[id] = sz - 4'd1;
            d             = modelMem[id][slot];
            known         = modelKnown[id][slot];
          end
        end
        default: begin
          // Read and element operations need an element below size
          if (int'(r.index) >= int'(sz)) begin
            e = errOutOfBounds;
          end else begin
            old   = modelMem[id][r.index];
            known = modelKnown[id][r.index];
            d     = old;
            if (r.op != opRead) begin
              modelMem[id][r.index] = elementValue(r.op, old, r.data);
              if (r.op != opAddAfter && r.op != opSubAfter) d = modelMem[id][r.index];
            end
          end
        end
      endcase
    end
  endtask

  //------------------------------------------------------------
  // Handshake driver
  //------------------------------------------------------------
  task automatic runRequest(input memRequest r, input int hold, input dataWord expData,
                            input memError expError, input bit dataKnown);
    memResponse got;
    @(negedge clock);
    request  = r;
    reqValid = 1'b1;
    do @(negedge clock); while (!ackValid);
    got = response;
    checkError("response.error", got.error, expError);
    if (dataKnown) checkData("response.data", got.data, expData);
    repeat (hold) begin
      @(negedge clock);
      if (!ackValid) reportFailure("ackValid fell while reqValid was still high");
      checkError("held response.error", response.error, expError);
      if (dataKnown) checkData("held response.data", response.data, expData);
      else checkData("held response.data", response.data, got.data);
    end
    reqValid = 1'b0;
    do @(negedge clock); while (ackValid);
  endtask

  //------------------------------------------------------------
  // Test sequence
  //------------------------------------------------------------
  initial begin
    memRequest r;
    dataWord   modelData;
    memError   modelError;
    bit        modelDataKnown;
    int        pick;
    void'($urandom(32'h15890a15));
    reset      = 1'b0;
    reqValid   = 1'b0;
    request    = '0;
    modelDepth = 0;
    modelNext  = 0;
    for (int a = 0; a < arrayCount; a++) begin
      modelAllocated[a] = 1'b0;
      modelSize[a]      = '0;
      for (int i = 0; i < arrayLength; i++) modelKnown[a][i] = 1'b0;
    end
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;

    // Directed table with the model kept in step for the random phase
    for (int v = 0; v < vectorCount; v++) begin
      r = '{vectors[v].op, vectors[v].array, vectors[v].index, vectors[v].data};
      applyModel(r, modelData, modelError, modelDataKnown);
      runRequest(r, int'(vectors[v].hold), vectors[v].expData, vectors[v].expError, 1'b1);
    end

    // Random mix with clear kept rare
    for (int n = 0; n < randomCount; n++) begin
      pick = int'($urandom % 20);
      if (pick >= 18) pick = 3 + 3 * (pick - 18);     // Extra writes and pushes
      if (pick == 0 && ($urandom % 8) != 0) pick = 1;
      r.op    = memOp'(pick);
      r.array = arrayId'($urandom);
      r.index = elementIndex'($urandom);
      r.data  = dataWord'($urandom);
      applyModel(r, modelData, modelError, modelDataKnown);
      runRequest(r, int'($urandom % 3), modelData, modelError, modelDataKnown);
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- arrayMem.f
+incdir+sim
verilog/arrayMemPkg.sv
verilog/requestPort.sv
verilog/arrayTable.sv
verilog/elementStore.sv
verilog/arrayMemTop.sv
sim/arrayMemTb.sv

//--- run.sh
#!/bin/sh
# Build and run the array memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f arrayMem.f --top-module arrayMemTb \
  -o arrayMemSim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/arrayMemSim > sim.log 2>&1 || true
cat sim.log

grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "Simulation did not complete"; exit 1; }
exit 0
